// ==== Makefile ====
# Verilator build for the front panel testbench

VERILATOR ?= verilator
TOP ?= frontPanel_tb
FILELIST ?= compile.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(wildcard *.sv) $(wildcard *.svh)
SIM := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf $(OBJDIR)

// ==== compile.f ====
+incdir+.
panel_pkg.sv
inputSampler.sv
stepRateGen.sv
probeSelect.sv
hexSegEncoder.sv
digitScanner.sv
frontPanel.sv
frontPanel_tb.sv

// ==== digitScanner.sv ====
`timescale 1ns/1ps
`include "panel_defs.svh"

module digitScanner import panel_pkg::*;
(
	input logic c100Hz,
	input logic arstN,
	input segWord_t segWord,
	output logic [`PANEL_SEG_W-1:0] seg,
	output logic [`PANEL_DIGITS-1:0] an
);

	localparam int IdxW = $clog2(`PANEL_DIGITS);

	scanState_t state;
	scanState_t nextState;
	logic [IdxW-1:0] digit;

	always_comb
	begin
		case (state)
			DIG0:
			begin
				digit = 2'd0;
				nextState = DIG1;
			end
			DIG1:
			begin
				digit = 2'd1;
				nextState = DIG2;
			end
			DIG2:
			begin
				digit = 2'd2;
				nextState = DIG3;
			end
			default:
			begin
				digit = 2'd3;
				nextState = DIG0;
			end
		endcase
	end

	// segments and anode switch on the same edge so no ghosting between digits
	always_ff @(posedge c100Hz or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= DIG0;
			seg <= '1;
			an <= '1;
		end
		else
		begin
			state <= nextState;
			seg <= ~segWord[digit];
			an <= ~(`PANEL_DIGITS'(1) << digit);
		end
	end

	oneAnodeActive: assert property (@(posedge c100Hz) disable iff (!arstN)
		$past(arstN) |-> $onehot(~an));

endmodule

// ==== frontPanel.sv ====
`timescale 1ns/1ps
`include "panel_defs.svh"

module frontPanel import panel_pkg::*;
(
	input logic c100Hz,
	input logic arstN,
	input logic [`PANEL_SW_W-1:0] sw,
	input logic [`PANEL_BTN_W-1:0] btn,
	input probeBus_t probe,
	output logic step,
	output logic [7:0] led,
	output logic [`PANEL_SEG_W-1:0] seg,
	output logic [`PANEL_DIGITS-1:0] an
);

	panelIn_t panelIn;
	ctrlReg_t ctrl;
	word_t dispWord;
	segWord_t segWord;

	inputSampler inputSampler_i
	(
		.c100Hz(c100Hz),
		.arstN(arstN),
		.sw(sw),
		.btn(btn),
		.panelIn(panelIn),
		.ctrl(ctrl)
	);

	stepRateGen stepRateGen_i
	(
		.c100Hz(c100Hz),
		.arstN(arstN),
		.ctrl(ctrl),
		.panelIn(panelIn),
		.step(step)
	);

	probeSelect probeSelect_i
	(
		.probe(probe),
		.sel(panelIn.sw[7:4]), // upper switches pick the observed word
		.dispWord(dispWord)
	);

	hexSegEncoder hexSegEncoder_i
	(
		.dispWord(dispWord),
		.upperHalf(panelIn.btn[3]),
		.rawMode(ctrl.rawMode),
		.segWord(segWord)
	);

	digitScanner digitScanner_i
	(
		.c100Hz(c100Hz),
		.arstN(arstN),
		.segWord(segWord),
		.seg(seg),
		.an(an)
	);

	// status view shows the memory strobe, the step pulse and the clock state
	always_comb
	begin
		if (ctrl.ledStatus)
			led = {1'b0, probe.memWrite, 1'b0, step, panelIn.btn[1], probe.clkStat};
		else
			led = probe.portB[7:0];
	end

endmodule

// ==== frontPanel_tb.sv ====
`timescale 1ns/1ps
`include "panel_defs.svh"

module frontPanel_tb import panel_pkg::*;
();

	localparam int ClkPeriod = 4;
	localparam int NumEntries = 16;
	localparam int SettleCycles = 10;
	localparam int StepWindow = 200;
	localparam int Presses = 3;
	localparam logic [7:0] HexSeg [16] = '{8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66, 8'h6D, 8'h7D,
		8'h07, 8'h7F, 8'h6F, 8'h77, 8'h7C, 8'h39, 8'h5E, 8'h79, 8'h71}; // b and d in lower case

	typedef struct packed
	{
		logic [7:0] ctrlVal;
		logic [3:0] sel;
		logic upper;
		logic statusView; // expected LED view, 1 for status and 0 for portB
	} entry_t;

	logic c100Hz;
	logic arstN;
	logic [7:0] sw;
	logic [3:0] btn;
	probeBus_t probe;
	logic step;
	logic [7:0] led;
	logic [7:0] seg;
	logic [3:0] an;

	entry_t stimTable [NumEntries];
	logic [31:0] rngState;
	int errors;
	int stepCount;
	logic scanOn;

	frontPanel dut_i
	(
		.c100Hz(c100Hz),
		.arstN(arstN),
		.sw(sw),
		.btn(btn),
		.probe(probe),
		.step(step),
		.led(led),
		.seg(seg),
		.an(an)
	);

	always #(ClkPeriod / 2) c100Hz = ~c100Hz;

	always @(negedge c100Hz)
	begin
		if (step)
			stepCount++;
		if (scanOn)
			checkValue("an low count", 32'($countones(~an)), 32'd1);
	end

	function automatic logic [31:0] nextRandom(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic word_t expectedWord(input probeBus_t p, input logic [3:0] sel);
		case (sel)
			4'h0: return p.portA;
			4'h1: return p.portB;
			4'h3: return p.portC;
			4'h4: return p.portD;
			4'h7: return p.tmr;
			4'h8: return p.ctr;
			4'h9: return p.tr;
			4'hA: return p.treg;
			4'hD: return p.mdi;
			4'hE: return p.mdo;
			4'hF: return p.addr;
			default: return '0;
		endcase
	endfunction

	function automatic logic [7:0] expectedSeg(input word_t w, input logic upper,
		input logic raw, input int d);
		logic [15:0] half;
		half = upper ? w[31:16] : w[15:0];
		if (raw)
			return w[d*8 +: 8];
		return HexSeg[half[d*4 +: 4]];
	endfunction

	function automatic logic [7:0] expectedLed(input entry_t e, input probeBus_t p);
		if (e.statusView)
			return {1'b0, p.memWrite, 3'b000, p.clkStat}; // step and load button idle here
		return p.portB[7:0];
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
		end
	endtask

	task automatic randomizeProbe();
		word_t w [11];
		for (int i = 0; i < 11; i++)
		begin
			rngState = nextRandom(rngState);
			w[i] = rngState;
		end
		rngState = nextRandom(rngState);
		probe = '{w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7], w[8], w[9], w[10],
			rngState[0], rngState[3:1]};
	endtask

	task automatic initTable();
		// ctrl load value, switch select, upper half, status view
		stimTable[0] = '{8'h00, 4'h0, 1'b0, 1'b0};
		stimTable[1] = '{8'h01, 4'h1, 1'b1, 1'b0};
		stimTable[2] = '{8'h02, 4'h2, 1'b0, 1'b0};
		stimTable[3] = '{8'h03, 4'h3, 1'b1, 1'b0};
		stimTable[4] = '{8'h04, 4'h4, 1'b0, 1'b0};
		stimTable[5] = '{8'h05, 4'h5, 1'b1, 1'b0};
		stimTable[6] = '{8'h06, 4'h6, 1'b0, 1'b0};
		stimTable[7] = '{8'h17, 4'h7, 1'b1, 1'b1};
		stimTable[8] = '{8'h08, 4'h8, 1'b0, 1'b0};
		stimTable[9] = '{8'h09, 4'h9, 1'b0, 1'b0};
		stimTable[10] = '{8'h0A, 4'hA, 1'b1, 1'b0};
		stimTable[11] = '{8'h1F, 4'hB, 1'b0, 1'b1};
		stimTable[12] = '{8'h0C, 4'hC, 1'b1, 1'b0};
		stimTable[13] = '{8'h07, 4'hD, 1'b0, 1'b0};
		stimTable[14] = '{8'hE5, 4'hE, 1'b1, 1'b0};
		stimTable[15] = '{8'h0E, 4'hF, 1'b1, 1'b0};
	endtask

	task automatic loadCtrl(input logic [7:0] value, input logic enable);
		@(negedge c100Hz);
		sw = value;
		btn[2] = enable;
		repeat (2) @(negedge c100Hz);
		btn[1] = 1'b1;
		repeat (4) @(negedge c100Hz);
		btn[1] = 1'b0;
		btn[2] = 1'b0;
		repeat (4) @(negedge c100Hz);
	endtask

	task automatic checkDisplay(input entry_t e);
		word_t w;
		logic [7:0] got [4];
		logic [3:0] seen;
		seen = '0;
		w = expectedWord(probe, e.sel);
		for (int c = 0; c < 4; c++)
		begin
			@(negedge c100Hz);
			for (int i = 0; i < 4; i++)
			begin
				if (!an[i])
				begin
					got[i] = ~seg; // store in active-high form
					seen[i] = 1'b1;
				end
			end
		end
		checkValue("digits scanned", 32'(seen), 32'hF);
		for (int d = 0; d < 4; d++)
			checkValue($sformatf("seg digit %0d", d), 32'(got[d]),
				32'(expectedSeg(w, e.upper, e.ctrlVal[3], d)));
	endtask

	task automatic checkStepRate(input logic [2:0] rate);
		int divisor;
		int expCount;
		int startCount;
		int count;
		case (rate)
			3'd0: divisor = `PANEL_DIV0;
			3'd1: divisor = `PANEL_DIV1;
			3'd2: divisor = `PANEL_DIV2;
			3'd3: divisor = `PANEL_DIV3;
			3'd4: divisor = `PANEL_DIV4;
			3'd5: divisor = `PANEL_DIV5;
			default: divisor = `PANEL_DIV6;
		endcase
		expCount = StepWindow / divisor;
		@(posedge c100Hz);
		startCount = stepCount;
		repeat (StepWindow) @(posedge c100Hz);
		count = stepCount - startCount;
		if (count >= expCount - 1 && count <= expCount + 1)
			count = expCount; // window phase may catch one pulse more or less
		checkValue("step count", count, expCount);
	endtask

	task automatic checkManualStep();
		int startCount;
		@(posedge c100Hz);
		startCount = stepCount;
		repeat (50) @(posedge c100Hz);
		checkValue("idle step count", stepCount - startCount, 0);
		for (int p = 0; p < Presses; p++)
		begin
			@(negedge c100Hz);
			btn[0] = 1'b1;
			repeat (4) @(negedge c100Hz);
			btn[0] = 1'b0;
			repeat (4) @(negedge c100Hz);
		end
		repeat (4) @(posedge c100Hz);
		checkValue("manual step count", stepCount - startCount, Presses);
	endtask

	task automatic applyEntry(input entry_t e);
		@(negedge c100Hz);
		randomizeProbe();
		loadCtrl(e.ctrlVal, 1'b1);
		sw = {e.sel, 4'h0};
		btn[3] = e.upper;
		repeat (SettleCycles) @(negedge c100Hz);
		loadCtrl(~e.ctrlVal, 1'b0); // load without enable must leave ctrl alone
		sw = {e.sel, 4'h0};
		repeat (SettleCycles) @(negedge c100Hz);
		checkValue("led", 32'(led), 32'(expectedLed(e, probe)));
		checkDisplay(e);
		if (e.ctrlVal[2:0] == 3'd7)
			checkManualStep();
		else
			checkStepRate(e.ctrlVal[2:0]);
	endtask

	initial
	begin
		c100Hz = 1'b0;
		arstN = 1'b0;
		sw = '0;
		btn = '0;
		errors = 0;
		stepCount = 0;
		scanOn = 1'b0;
		rngState = 32'h1f4a067a;
		initTable();
		randomizeProbe();
		repeat (5) @(posedge c100Hz);
		@(negedge c100Hz);
		arstN = 1'b1;
		checkValue("an after reset", 32'(an), 32'hF);
		checkValue("step after reset", 32'(step), 32'd0);
		@(posedge c100Hz);
		scanOn = 1'b1;
		repeat (3) @(negedge c100Hz);
		checkValue("led after reset", 32'(led), 32'(probe.portB[7:0]));
		foreach (stimTable[n])
			applyEntry(stimTable[n]);
		$display("Test finished with %0d errors", errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin
		#(NumEntries * 300 * ClkPeriod);
		$display("Watchdog expired after %0d cycles before the tests finished", NumEntries * 300);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== hexSegEncoder.sv ====
`timescale 1ns/1ps
`include "panel_defs.svh"

module hexSegEncoder import panel_pkg::*;
(
	input word_t dispWord,
	input logic upperHalf,
	input logic rawMode,
	output segWord_t segWord
);

	localparam int HalfW = `PANEL_WORD_W / 2;

	logic [HalfW-1:0] half;
	segWord_t hexWord;

	// bit order dp g f e d c b a, decimal point left dark
	function automatic segByte_t nibbleToSeg(input logic [3:0] nib);
		segByte_t pattern;
		case (nib)
			4'h0: pattern = 8'h3F;
			4'h1: pattern = 8'h06;
			4'h2: pattern = 8'h5B;
			4'h3: pattern = 8'h4F;
			4'h4: pattern = 8'h66;
			4'h5: pattern = 8'h6D;
			4'h6: pattern = 8'h7D;
			4'h7: pattern = 8'h07;
			4'h8: pattern = 8'h7F;
			4'h9: pattern = 8'h6F;
			4'hA: pattern = 8'h77;
			4'hB: pattern = 8'h7C; // lower case b so it differs from 8
			4'hC: pattern = 8'h39;
			4'hD: pattern = 8'h5E; // lower case d so it differs from 0
			4'hE: pattern = 8'h79;
			default: pattern = 8'h71;
		endcase
		return pattern;
	endfunction

	assign half = upperHalf ? dispWord[`PANEL_WORD_W-1:HalfW] : dispWord[HalfW-1:0];

	always_comb
	begin
		for (int i = 0; i < `PANEL_DIGITS; i++)
			hexWord[i] = nibbleToSeg(half[i*4 +: 4]);
	end

	// raw mode lets the program draw its own segment patterns
	assign segWord = rawMode ? segWord_t'(dispWord) : hexWord;

endmodule

// ==== inputSampler.sv ====
`timescale 1ns/1ps
`include "panel_defs.svh"

module inputSampler import panel_pkg::*;
(
	input logic c100Hz,
	input logic arstN,
	input logic [`PANEL_SW_W-1:0] sw,
	input logic [`PANEL_BTN_W-1:0] btn,
	output panelIn_t panelIn,
	output ctrlReg_t ctrl
);

	panelIn_t syncStage;
	logic loadPrev;
	logic loadEdge;

	// button 1 loads, button 2 must be held to enable the load
	assign loadEdge = panelIn.btn[1] & ~loadPrev;

	always_ff @(posedge c100Hz or negedge arstN)
	begin
		if (!arstN)
		begin
			syncStage <= '0;
			panelIn <= '0;
		end
		else
		begin
			syncStage <= panelIn_t'({sw, btn}); // first stage may go metastable
			panelIn <= syncStage;
		end
	end

	always_ff @(posedge c100Hz or negedge arstN)
	begin
		if (!arstN)
		begin
			loadPrev <= 1'b0;
			ctrl <= '0;
		end
		else
		begin
			loadPrev <= panelIn.btn[1];
			if (loadEdge && panelIn.btn[2])
				ctrl <= ctrlReg_t'(panelIn.sw);
		end
	end

	// the register only moves on a qualified load edge
	ctrlLoadOnly: assert property (@(posedge c100Hz) disable iff (!arstN)
		!$stable(ctrl) |-> $past(loadEdge && panelIn.btn[2]));

endmodule

// ==== panel_defs.svh ====
`ifndef PANEL_DEFS_SVH
`define PANEL_DEFS_SVH

// observation word and display geometry
`define PANEL_WORD_W 32
`define PANEL_DIGITS 4
`define PANEL_SEG_W 8

// front panel inputs
`define PANEL_SW_W 8
`define PANEL_BTN_W 4

// step rate counter, wide enough for the slowest divisor
`define PANEL_RATE_W 7

// c100Hz cycles per step for rate codes 0 to 6
`define PANEL_DIV0 1
`define PANEL_DIV1 2
`define PANEL_DIV2 5
`define PANEL_DIV3 10
`define PANEL_DIV4 20
`define PANEL_DIV5 50
`define PANEL_DIV6 100

`endif

// ==== panel_pkg.sv ====
`include "panel_defs.svh"

package panel_pkg;

	typedef logic [`PANEL_WORD_W-1:0] word_t;
	typedef logic [`PANEL_SEG_W-1:0] segByte_t; // dp g f e d c b a, active high
	typedef segByte_t [`PANEL_DIGITS-1:0] segWord_t; // digit 0 in the lowest byte
	typedef logic [2:0] rateCode_t;
	typedef logic [`PANEL_RATE_W-1:0] rateCnt_t;

	typedef struct packed
	{
		logic [2:0] spare; // loaded with the switches but not decoded
		logic ledStatus;
		logic rawMode;
		rateCode_t rate;
	} ctrlReg_t;

	typedef struct packed
	{
		word_t portA;
		word_t portB;
		word_t portC;
		word_t portD;
		word_t tmr;
		word_t ctr;
		word_t tr;
		word_t treg;
		word_t mdi;
		word_t mdo;
		word_t addr;
		logic memWrite;
		logic [2:0] clkStat;
	} probeBus_t;

	typedef struct packed
	{
		logic [`PANEL_SW_W-1:0] sw;
		logic [`PANEL_BTN_W-1:0] btn;
	} panelIn_t;

	typedef enum logic [1:0] {DIG0, DIG1, DIG2, DIG3} scanState_t;

endpackage

// ==== probeSelect.sv ====
`timescale 1ns/1ps
`include "panel_defs.svh"

module probeSelect import panel_pkg::*;
(
	input probeBus_t probe,
	input logic [3:0] sel,
	output word_t dispWord
);

	always_comb
	begin
		case (sel)
			4'h0:
				dispWord = probe.portA;
			4'h1:
				dispWord = probe.portB;
			4'h3:
				dispWord = probe.portC;
			4'h4:
				dispWord = probe.portD;
			4'h7:
				dispWord = probe.tmr;
			4'h8:
				dispWord = probe.ctr;
			4'h9:
				dispWord = probe.tr;
			4'hA:
				dispWord = probe.treg;
			4'hD:
				dispWord = probe.mdi;
			4'hE:
				dispWord = probe.mdo;
			4'hF:
				dispWord = probe.addr;
			default:
				dispWord = '0; // codes 2, 5, 6, B and C have no source
		endcase
	end

endmodule

// ==== stepRateGen.sv ====
`timescale 1ns/1ps
`include "panel_defs.svh"

module stepRateGen import panel_pkg::*;
(
	input logic c100Hz,
	input logic arstN,
	input ctrlReg_t ctrl,
	input panelIn_t panelIn,
	output logic step
);

	rateCnt_t divisor;
	rateCnt_t count;
	rateCode_t prevRate;
	logic btn0Prev;
	logic manual;
	logic restart;

	assign manual = (ctrl.rate == 3'd7);
	assign restart = (ctrl.rate != prevRate); // any new code starts a fresh period

	always_comb
	begin
		case (ctrl.rate)
			3'd0: divisor = rateCnt_t'(`PANEL_DIV0);
			3'd1: divisor = rateCnt_t'(`PANEL_DIV1);
			3'd2: divisor = rateCnt_t'(`PANEL_DIV2);
			3'd3: divisor = rateCnt_t'(`PANEL_DIV3);
			3'd4: divisor = rateCnt_t'(`PANEL_DIV4);
			3'd5: divisor = rateCnt_t'(`PANEL_DIV5);
			3'd6: divisor = rateCnt_t'(`PANEL_DIV6);
			default: divisor = '0; // manual stepping, the counter idles
		endcase
	end

	always_ff @(posedge c100Hz or negedge arstN)
	begin
		if (!arstN)
		begin
			count <= '0;
			prevRate <= '0;
			btn0Prev <= 1'b0;
			step <= 1'b0;
		end
		else
		begin
			prevRate <= ctrl.rate;
			btn0Prev <= panelIn.btn[0];
			if (restart)
			begin
				count <= divisor - 1'b1;
				step <= 1'b0;
			end
			else if (manual)
				step <= panelIn.btn[0] & ~btn0Prev; // one step per press
			else if (count == '0)
			begin
				count <= divisor - 1'b1;
				step <= 1'b1;
			end
			else
			begin
				count <= count - 1'b1;
				step <= 1'b0;
			end
		end
	end

	// only the fastest rate may hold step high
	stepIsPulse: assert property (@(posedge c100Hz) disable iff (!arstN)
		step && (divisor != rateCnt_t'(1)) |=> !step);

endmodule
